// ==== hdl/conv_param_pkg.sv ====
package conv_param_pkg;

  // pixel, weight and bias word
  localparam int DWIDTH = 16;

  // layer sizes, channel counts and scan positions
  localparam int LWIDTH = 8;

  // sum wraps to the data word
  localparam int ACC_WIDTH = DWIDTH;

endpackage

// ==== hdl/conv_state_pkg.sv ====
package conv_state_pkg;

  // main controller sequence
  typedef enum logic [1:0] {
    S_WAIT    = 2'd0,
    S_NETWORK = 2'd1,
    S_INPUT   = 2'd2,
    S_OUTPUT  = 2'd3
  } core_state_t;

  // what the network read is fetching
  typedef enum logic {
    S_W_WEIGHT = 1'b0,
    S_W_BIAS   = 1'b1
  } weight_phase_t;

endpackage

// ==== hdl/xy_counter.sv ====
module xy_counter #(
  parameter int MAX_FIL = 4,
  localparam int IWIDTH = (MAX_FIL > 1) ? $clog2(MAX_FIL * MAX_FIL) : 1
) (
  input  logic                              clk,
  input  logic                              xrst,
  input  logic                              run,
  input  logic [conv_param_pkg::LWIDTH-1:0] size,
  output logic [conv_param_pkg::LWIDTH-1:0] x,
  output logic [conv_param_pkg::LWIDTH-1:0] y,
  output logic [IWIDTH-1:0]                 idx,
  output logic                              last
);

  logic x_end;

  assign x_end = x == size - 1'b1;
  assign last  = x_end && y == size - 1'b1;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      x   <= '0;
      y   <= '0;
      idx <= '0;
    end else if (!run || last) begin
      x   <= '0;
      y   <= '0;
      idx <= '0;
    end else if (x_end) begin
      x   <= '0;
      y   <= y + 1'b1;
      idx <= idx + 1'b1;
    end else begin
      x   <= x + 1'b1;
      idx <= idx + 1'b1;
    end
  end

endmodule

// ==== hdl/conv_mem.sv ====
module conv_mem #(
  parameter int AWIDTH = 10
) (
  input  logic                              clk,
  input  logic                              we,
  input  logic [AWIDTH-1:0]                 addr,
  input  logic [conv_param_pkg::DWIDTH-1:0] wdata,
  output logic [conv_param_pkg::DWIDTH-1:0] rdata
);

  logic [conv_param_pkg::DWIDTH-1:0] mem [2**AWIDTH];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
  end

  // registered read, data one cycle after addr
  always_ff @(posedge clk) begin
    rdata <= mem[addr];
  end

endmodule

// ==== hdl/conv_ctrl.sv ====
module conv_ctrl #(
  parameter int IMGSIZE = 10,
  parameter int NETSIZE = 10,
  parameter int MAX_FIL = 4,
  localparam int IWIDTH = (MAX_FIL > 1) ? $clog2(MAX_FIL * MAX_FIL) : 1
) (
  input  logic                              clk,
  input  logic                              xrst,
  input  logic                              req,
  input  logic [conv_param_pkg::LWIDTH-1:0] total_in,
  input  logic [conv_param_pkg::LWIDTH-1:0] total_out,
  input  logic [conv_param_pkg::LWIDTH-1:0] fil_size,
  input  logic [IMGSIZE-1:0]                in_offset,
  input  logic [IMGSIZE-1:0]                out_offset,
  input  logic [NETSIZE-1:0]                net_offset,
  input  logic [conv_param_pkg::DWIDTH-1:0] out_value,
  output logic                              ack,
  output conv_state_pkg::core_state_t       core_state,
  output logic                              w_run,
  output logic [conv_param_pkg::LWIDTH-1:0] w_size,
  input  logic [IWIDTH-1:0]                 w_idx,
  input  logic                              w_last,
  output logic                              p_run,
  output logic [conv_param_pkg::LWIDTH-1:0] p_size,
  input  logic [IWIDTH-1:0]                 p_idx,
  input  logic                              p_last,
  output logic                              mem_img_we,
  output logic [IMGSIZE-1:0]                mem_img_addr,
  output logic [conv_param_pkg::DWIDTH-1:0] mem_img_wdata,
  output logic [NETSIZE-1:0]                mem_net_addr,
  output logic                              wreg_we,
  output logic [IWIDTH-1:0]                 wreg_idx,
  output logic                              breg_we,
  output logic                              pix_en,
  output logic [IWIDTH-1:0]                 pix_idx,
  output logic                              acc_clear
);

  conv_state_pkg::core_state_t   state;
  conv_state_pkg::weight_phase_t phase;

  logic [conv_param_pkg::LWIDTH-1:0] total_in_r;
  logic [conv_param_pkg::LWIDTH-1:0] total_out_r;
  logic [conv_param_pkg::LWIDTH-1:0] fil_size_r;
  logic [conv_param_pkg::LWIDTH-1:0] count_in;
  logic [conv_param_pkg::LWIDTH-1:0] count_out;
  logic [IMGSIZE-1:0]                in_offset_r;
  logic [IMGSIZE-1:0]                out_offset_r;
  logic [IMGSIZE-1:0]                in_addr;
  logic [NETSIZE-1:0]                net_addr;
  logic                              out_step;
  logic                              start;
  logic                              last_in;
  logic                              last_out;
  logic                              network_end;
  logic                              output_end;

// ==========================================================================
// main sequence
// ==========================================================================

  assign start    = state == conv_state_pkg::S_WAIT && req;
  assign last_in  = count_in == total_in_r - 1'b1;
  assign last_out = count_out == total_out_r - 1'b1;

  // bias word follows the weights of the last input channel
  assign network_end = state == conv_state_pkg::S_NETWORK
                    && (last_in ? phase == conv_state_pkg::S_W_BIAS : w_last);
  assign output_end  = state == conv_state_pkg::S_OUTPUT && out_step;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state     <= conv_state_pkg::S_WAIT;
      count_in  <= '0;
      count_out <= '0;
    end else begin
      case (state)
        conv_state_pkg::S_WAIT:
          if (req) state <= conv_state_pkg::S_NETWORK;
        conv_state_pkg::S_NETWORK:
          if (network_end) state <= conv_state_pkg::S_INPUT;
        conv_state_pkg::S_INPUT:
          if (p_last) begin
            if (last_in) begin
              state    <= conv_state_pkg::S_OUTPUT;
              count_in <= '0;
            end else begin
              state    <= conv_state_pkg::S_NETWORK;
              count_in <= count_in + 1'b1;
            end
          end
        conv_state_pkg::S_OUTPUT:
          if (out_step) begin
            if (last_out) begin
              state     <= conv_state_pkg::S_WAIT;
              count_out <= '0;
            end else begin
              state     <= conv_state_pkg::S_NETWORK;
              count_out <= count_out + 1'b1;
            end
          end
        default:
          state <= conv_state_pkg::S_WAIT;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      phase <= conv_state_pkg::S_W_WEIGHT;
    end else if (phase == conv_state_pkg::S_W_BIAS) begin
      phase <= conv_state_pkg::S_W_WEIGHT;
    end else if (state == conv_state_pkg::S_NETWORK && w_last && last_in) begin
      phase <= conv_state_pkg::S_W_BIAS;
    end
  end

  // job parameters, held for the whole run
  always_ff @(posedge clk) begin
    if (!xrst) begin
      total_in_r   <= '0;
      total_out_r  <= '0;
      fil_size_r   <= '0;
      in_offset_r  <= '0;
      out_offset_r <= '0;
    end else if (start) begin
      total_in_r   <= total_in;
      total_out_r  <= total_out;
      fil_size_r   <= fil_size;
      in_offset_r  <= in_offset;
      out_offset_r <= out_offset;
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      ack      <= 1'b1;
      out_step <= 1'b0;
    end else begin
      out_step <= state == conv_state_pkg::S_OUTPUT && !out_step;
      if (start) ack <= 1'b0;
      else if (output_end && last_out) ack <= 1'b1;
    end
  end

  assign core_state = state;

// ==========================================================================
// addresses and counters
// ==========================================================================

  assign w_run  = state == conv_state_pkg::S_NETWORK && phase == conv_state_pkg::S_W_WEIGHT;
  assign w_size = fil_size_r;
  assign p_run  = state == conv_state_pkg::S_INPUT;
  assign p_size = fil_size_r;

  // input scan restarts for every output channel
  always_ff @(posedge clk) begin
    if (!xrst) begin
      in_addr  <= '0;
      net_addr <= '0;
    end else if (start) begin
      in_addr  <= in_offset;
      net_addr <= net_offset;
    end else begin
      if (p_run) in_addr <= in_addr + 1'b1;
      else if (output_end) in_addr <= in_offset_r;
      if (state == conv_state_pkg::S_NETWORK) net_addr <= net_addr + 1'b1;
    end
  end

  assign mem_net_addr  = net_addr;
  assign mem_img_we    = output_end;
  assign mem_img_wdata = out_value;
  assign mem_img_addr  = state == conv_state_pkg::S_OUTPUT
                       ? out_offset_r + IMGSIZE'(count_out)
                       : in_addr;

// ==========================================================================
// strobes to the mac, one cycle behind the memory address
// ==========================================================================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      wreg_we   <= 1'b0;
      breg_we   <= 1'b0;
      pix_en    <= 1'b0;
      acc_clear <= 1'b0;
    end else begin
      wreg_we   <= w_run;
      breg_we   <= state == conv_state_pkg::S_NETWORK && phase == conv_state_pkg::S_W_BIAS;
      pix_en    <= p_run;
      acc_clear <= start || (output_end && !last_out);
    end
  end

  always_ff @(posedge clk) begin
    wreg_idx <= w_idx;
    pix_idx  <= p_idx;
  end

  a_fil_size: assert property (@(posedge clk) disable iff (!xrst)
    start |-> (fil_size >= 1 && fil_size <= MAX_FIL));

  // host waits for ack before the next job
  a_req_busy: assert property (@(posedge clk) disable iff (!xrst)
    !ack |-> !req);

endmodule

// ==== hdl/conv_mac.sv ====
module conv_mac #(
  parameter int MAX_FIL = 4,
  localparam int IWIDTH = (MAX_FIL > 1) ? $clog2(MAX_FIL * MAX_FIL) : 1,
  localparam int DEPTH = MAX_FIL * MAX_FIL
) (
  input  logic                              clk,
  input  logic                              xrst,
  input  logic                              wreg_we,
  input  logic [IWIDTH-1:0]                 wreg_idx,
  input  logic                              breg_we,
  input  logic [conv_param_pkg::DWIDTH-1:0] wdata,
  input  logic                              pix_en,
  input  logic [IWIDTH-1:0]                 pix_idx,
  input  logic [conv_param_pkg::DWIDTH-1:0] pixel,
  input  logic                              acc_clear,
  output logic [conv_param_pkg::DWIDTH-1:0] out_value
);

  logic [conv_param_pkg::DWIDTH-1:0]    wreg [DEPTH];
  logic [conv_param_pkg::DWIDTH-1:0]    breg;
  logic [conv_param_pkg::ACC_WIDTH-1:0] acc;
  logic [conv_param_pkg::ACC_WIDTH-1:0] product;
  logic [IWIDTH:0]                      loaded;

  always_ff @(posedge clk) begin
    if (wreg_we) begin
      wreg[wreg_idx] <= wdata;
    end
    if (breg_we) begin
      breg <= wdata;
    end
  end

  // low half of the product is all that survives the wrap
  assign product = conv_param_pkg::ACC_WIDTH'(pixel * wreg[pix_idx]);

  always_ff @(posedge clk) begin
    if (!xrst) begin
      acc <= '0;
    end else if (acc_clear) begin
      acc <= '0;
    end else if (pix_en) begin
      acc <= acc + product;
    end
  end

  assign out_value = acc + breg;

  // number of weights in the latest load
  always_ff @(posedge clk) begin
    if (!xrst) begin
      loaded <= '0;
    end else if (wreg_we) begin
      loaded <= {1'b0, wreg_idx} + 1'b1;
    end
  end

  // weights arrive in scan order from index 0
  a_wreg_idx: assert property (@(posedge clk) disable iff (!xrst)
    wreg_we |-> {1'b0, wreg_idx} == ($past(wreg_we) ? loaded : '0));

  // pixels only use weights of the latest load, never past MAX_FIL squared
  a_pix_idx: assert property (@(posedge clk) disable iff (!xrst)
    pix_en |-> pix_idx < loaded);

endmodule

// ==== hdl/conv_top.sv ====
module conv_top #(
  parameter int IMGSIZE = 10,
  parameter int NETSIZE = 10,
  parameter int MAX_FIL = 4
) (
  input  logic                              clk,
  input  logic                              xrst,
  input  logic                              req,
  input  logic [conv_param_pkg::LWIDTH-1:0] total_in,
  input  logic [conv_param_pkg::LWIDTH-1:0] total_out,
  input  logic [conv_param_pkg::LWIDTH-1:0] fil_size,
  input  logic [IMGSIZE-1:0]                in_offset,
  input  logic [IMGSIZE-1:0]                out_offset,
  input  logic [NETSIZE-1:0]                net_offset,
  input  logic                              host_img_we,
  input  logic [IMGSIZE-1:0]                host_img_addr,
  input  logic [conv_param_pkg::DWIDTH-1:0] host_img_wdata,
  input  logic                              host_net_we,
  input  logic [NETSIZE-1:0]                host_net_addr,
  input  logic [conv_param_pkg::DWIDTH-1:0] host_net_wdata,
  output logic [conv_param_pkg::DWIDTH-1:0] img_rdata,
  output logic                              ack,
  output conv_state_pkg::core_state_t       core_state
);

  localparam int IWIDTH = (MAX_FIL > 1) ? $clog2(MAX_FIL * MAX_FIL) : 1;

  logic                              w_run, w_last, p_run, p_last;
  logic [conv_param_pkg::LWIDTH-1:0] w_size, p_size;
  logic [IWIDTH-1:0]                 w_idx, p_idx, wreg_idx, pix_idx;
  logic                              mem_img_we, wreg_we, breg_we, pix_en, acc_clear;
  logic [IMGSIZE-1:0]                mem_img_addr, img_addr;
  logic [NETSIZE-1:0]                mem_net_addr, net_addr;
  logic [conv_param_pkg::DWIDTH-1:0] mem_img_wdata, img_wdata, net_rdata, out_value;
  logic                              img_we, net_we;

  conv_ctrl #(.IMGSIZE(IMGSIZE), .NETSIZE(NETSIZE), .MAX_FIL(MAX_FIL)) u_ctrl (.*);

  xy_counter #(.MAX_FIL(MAX_FIL)) u_w_cnt (
    .clk, .xrst, .run(w_run), .size(w_size), .x(), .y(), .idx(w_idx), .last(w_last)
  );

  xy_counter #(.MAX_FIL(MAX_FIL)) u_p_cnt (
    .clk, .xrst, .run(p_run), .size(p_size), .x(), .y(), .idx(p_idx), .last(p_last)
  );

  // host owns both memories while idle
  assign img_we    = ack ? host_img_we : mem_img_we;
  assign img_addr  = ack ? host_img_addr : mem_img_addr;
  assign img_wdata = ack ? host_img_wdata : mem_img_wdata;
  assign net_we    = ack && host_net_we;
  assign net_addr  = ack ? host_net_addr : mem_net_addr;

  conv_mem #(.AWIDTH(IMGSIZE)) u_img_mem (
    .clk, .we(img_we), .addr(img_addr), .wdata(img_wdata), .rdata(img_rdata)
  );

  conv_mem #(.AWIDTH(NETSIZE)) u_net_mem (
    .clk, .we(net_we), .addr(net_addr), .wdata(host_net_wdata), .rdata(net_rdata)
  );

  conv_mac #(.MAX_FIL(MAX_FIL)) u_mac (
    .clk, .xrst, .wreg_we, .wreg_idx, .breg_we, .wdata(net_rdata),
    .pix_en, .pix_idx, .pixel(img_rdata), .acc_clear, .out_value
  );

endmodule

// ==== tb/tb_conv_top.sv ====
module tb_conv_top;

  localparam int IMGSIZE = 10;
  localparam int NETSIZE = 10;
  localparam int MAX_FIL = 4;
  localparam int NUM_JOBS = 5;
  localparam int FILL_MARGIN = 4 * (1 << IMGSIZE);

  // job table columns
  localparam int C_IN = 0;
  localparam int C_OUT = 1;
  localparam int C_FIL = 2;
  localparam int C_IN_OFF = 3;
  localparam int C_OUT_OFF = 4;
  localparam int C_NET_OFF = 5;

  // total_in, total_out, fil_size, in_offset, out_offset, net_offset
  int jobs [NUM_JOBS][6] = '{
    '{1, 1, 1, 'h010, 'h100, 'h000},
    '{3, 1, 4, 'h020, 'h200, 'h040},
    '{2, 4, 3, 'h000, 'h300, 'h100},
    '{2, 3, 2, 'h080, 'h3f0, 'h200},
    '{4, 2, 4, 'h150, 'h2f0, 'h300}
  };

  logic                              clk;
  logic                              xrst;
  logic                              req;
  logic [conv_param_pkg::LWIDTH-1:0] total_in;
  logic [conv_param_pkg::LWIDTH-1:0] total_out;
  logic [conv_param_pkg::LWIDTH-1:0] fil_size;
  logic [IMGSIZE-1:0]                in_offset;
  logic [IMGSIZE-1:0]                out_offset;
  logic [NETSIZE-1:0]                net_offset;
  logic                              host_img_we;
  logic [IMGSIZE-1:0]                host_img_addr;
  logic [conv_param_pkg::DWIDTH-1:0] host_img_wdata;
  logic                              host_net_we;
  logic [NETSIZE-1:0]                host_net_addr;
  logic [conv_param_pkg::DWIDTH-1:0] host_net_wdata;
  logic [conv_param_pkg::DWIDTH-1:0] img_rdata;
  logic                              ack;
  conv_state_pkg::core_state_t       core_state;

  // shadow copies of what the host wrote
  logic [conv_param_pkg::DWIDTH-1:0] img_model [1 << IMGSIZE];
  logic [conv_param_pkg::DWIDTH-1:0] net_model [1 << NETSIZE];

  int checks;
  int errors;

  conv_top #(.IMGSIZE(IMGSIZE), .NETSIZE(NETSIZE), .MAX_FIL(MAX_FIL)) DUT (
    .clk(clk), .xrst(xrst), .req(req), .total_in(total_in), .total_out(total_out),
    .fil_size(fil_size), .in_offset(in_offset), .out_offset(out_offset),
    .net_offset(net_offset), .host_img_we(host_img_we), .host_img_addr(host_img_addr),
    .host_img_wdata(host_img_wdata), .host_net_we(host_net_we),
    .host_net_addr(host_net_addr), .host_net_wdata(host_net_wdata),
    .img_rdata(img_rdata), .ack(ack), .core_state(core_state)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [conv_param_pkg::DWIDTH-1:0] got,
                             input logic [conv_param_pkg::DWIDTH-1:0] expected);
    checks++;
    if (got !== expected) begin
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, expected);
      errors++;
    end
  endtask

// ==========================================================================
// host access and reference model
// ==========================================================================

  task automatic fill_memories();
    logic [conv_param_pkg::DWIDTH-1:0] pix;
    logic [conv_param_pkg::DWIDTH-1:0] wgt;
    for (int a = 0; a < (1 << IMGSIZE); a++) begin
      pix = $urandom;
      wgt = $urandom;
      img_model[a] = pix;
      net_model[a] = wgt;
      @(posedge clk);
      host_img_we    <= 1'b1;
      host_img_addr  <= a[IMGSIZE-1:0];
      host_img_wdata <= pix;
      host_net_we    <= 1'b1;
      host_net_addr  <= a[NETSIZE-1:0];
      host_net_wdata <= wgt;
    end
    @(posedge clk);
    host_img_we <= 1'b0;
    host_net_we <= 1'b0;
  endtask

  // registered read, data valid one cycle after the address
  task automatic read_image(input int addr, output logic [conv_param_pkg::DWIDTH-1:0] data);
    @(posedge clk);
    host_img_addr <= addr[IMGSIZE-1:0];
    @(posedge clk);
    @(negedge clk);
    data = img_rdata;
  endtask

  function automatic logic [conv_param_pkg::DWIDTH-1:0] expected_output(input int j,
                                                                         input int o);
    int kk;
    int w_base;
    logic [conv_param_pkg::DWIDTH-1:0] sum;
    kk = jobs[j][C_FIL] * jobs[j][C_FIL];
    // each output channel owns total_in*k*k weights and one bias
    w_base = jobs[j][C_NET_OFF] + o * (jobs[j][C_IN] * kk + 1);
    sum = '0;
    for (int c = 0; c < jobs[j][C_IN]; c++) begin
      for (int p = 0; p < kk; p++) begin
        sum = sum + img_model[jobs[j][C_IN_OFF] + c * kk + p] * net_model[w_base + c * kk + p];
      end
    end
    return sum + net_model[w_base + jobs[j][C_IN] * kk];
  endfunction

  task automatic run_job(input int j);
    int kk;
    int errors_before;
    logic [conv_param_pkg::DWIDTH-1:0] data;
    errors_before = errors;
    kk = jobs[j][C_FIL] * jobs[j][C_FIL];
    fill_memories();
    @(posedge clk);
    req        <= 1'b1;
    total_in   <= jobs[j][C_IN];
    total_out  <= jobs[j][C_OUT];
    fil_size   <= jobs[j][C_FIL];
    in_offset  <= jobs[j][C_IN_OFF];
    out_offset <= jobs[j][C_OUT_OFF];
    net_offset <= jobs[j][C_NET_OFF];
    @(posedge clk);
    req <= 1'b0;
    @(negedge clk);
    check_value("ack", ack, 1'b0);
    check_value("core_state", core_state, conv_state_pkg::S_NETWORK);
    while (ack !== 1'b1) @(negedge clk);
    for (int o = 0; o < jobs[j][C_OUT]; o++) begin
      read_image(jobs[j][C_OUT_OFF] + o, data);
      check_value($sformatf("out[%0d]", o), data, expected_output(j, o));
    end
    // input words must survive the run
    for (int i = 0; i < jobs[j][C_IN] * kk; i++) begin
      read_image(jobs[j][C_IN_OFF] + i, data);
      check_value($sformatf("img[0x%h]", jobs[j][C_IN_OFF] + i), data,
                  img_model[jobs[j][C_IN_OFF] + i]);
    end
    $display("job %0d: in=%0d out=%0d k=%0d, %0d errors", j, jobs[j][C_IN],
             jobs[j][C_OUT], jobs[j][C_FIL], errors - errors_before);
  endtask

// ==========================================================================
// main sequence and watchdog
// ==========================================================================

  initial begin
    void'($urandom(474));
    checks         = 0;
    errors         = 0;
    xrst           = 1'b0;
    req            = 1'b0;
    total_in       = '0;
    total_out      = '0;
    fil_size       = '0;
    in_offset      = '0;
    out_offset     = '0;
    net_offset     = '0;
    host_img_we    = 1'b0;
    host_img_addr  = '0;
    host_img_wdata = '0;
    host_net_we    = 1'b0;
    host_net_addr  = '0;
    host_net_wdata = '0;
    repeat (3) @(posedge clk);
    xrst <= 1'b1;
    @(negedge clk);
    check_value("ack", ack, 1'b1);
    check_value("core_state", core_state, conv_state_pkg::S_WAIT);
    $display("reset: %0d errors", errors);
    for (int j = 0; j < NUM_JOBS; j++) begin
      run_job(j);
    end
    $display("%0d jobs, %0d checks, %0d errors", NUM_JOBS, checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    int limit;
    #1;
    limit = 0;
    for (int j = 0; j < NUM_JOBS; j++) begin
      limit += jobs[j][C_OUT] * (2 * jobs[j][C_IN] * jobs[j][C_FIL] * jobs[j][C_FIL] + 4);
    end
    limit = 2 * limit + NUM_JOBS * FILL_MARGIN;
    repeat (limit) @(posedge clk);
    $display("timeout: ack never rose within %0d cycles", limit);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// ==== conv_top.f ====
hdl/conv_param_pkg.sv
hdl/conv_state_pkg.sv
hdl/xy_counter.sv
hdl/conv_mem.sv
hdl/conv_ctrl.sv
hdl/conv_mac.sv
hdl/conv_top.sv
tb/tb_conv_top.sv
